//--- hdl/sb_spi_regs.sv
module sb_spi_regs (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  spi_bus_pkg::sb_req_t  sb_req,
	input  logic                  sb_stb,
	output logic                  sb_ack,
	output spi_bus_pkg::sb_data_t sb_rdata,
	output logic                  tx_start,
	output spi_bus_pkg::sb_data_t tx_byte,
	output logic                  cs_active,
	output spi_bus_pkg::sb_data_t clk_div,
	input  logic                  busy,
	input  logic                  rx_valid,
	input  spi_bus_pkg::sb_data_t rx_byte
);

	logic take;    // a strobed request not yet acknowledged.
	logic tx_idle;
	logic tx_load;
	logic rrdy;

	spi_bus_pkg::sb_data_t rx_r;
	spi_bus_pkg::sb_data_t rd_mux;

	assign take = sb_stb && !sb_ack;

	// a start issued last cycle has not reached the shifter's busy yet.
	assign tx_idle = !(busy || tx_start);
	assign tx_load = take && sb_req.rw && (sb_req.addr == spi_bus_pkg::SB_SPITXDR) && tx_idle;

	always_comb begin
		rd_mux = '0;
		case (sb_req.addr)
			spi_bus_pkg::SB_SPICSR:  rd_mux[0] = cs_active;
			spi_bus_pkg::SB_SPIBR:   rd_mux = clk_div;
			spi_bus_pkg::SB_SPITXDR: rd_mux = tx_byte;
			spi_bus_pkg::SB_SPIRXDR: rd_mux = rx_r;
			spi_bus_pkg::SB_SPISR: begin
				rd_mux[spi_bus_pkg::SR_TRDY] = tx_idle;
				rd_mux[spi_bus_pkg::SR_RRDY] = rrdy;
			end
			default: rd_mux = '0;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control registers and handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			sb_ack    <= 1'b0;
			tx_start  <= 1'b0;
			cs_active <= 1'b0;
			clk_div   <= '0;
			rrdy      <= 1'b0;
		end else begin
			sb_ack   <= take;
			tx_start <= tx_load; // a write while busy is acknowledged and dropped.
			if (take && sb_req.rw) begin
				case (sb_req.addr)
					spi_bus_pkg::SB_SPICSR: cs_active <= sb_req.wdata[0];
					spi_bus_pkg::SB_SPIBR:  clk_div <= sb_req.wdata;
					default: ;
				endcase
			end
			if (rx_valid) begin
				rrdy <= 1'b1;
			end else if (take && !sb_req.rw && sb_req.addr == spi_bus_pkg::SB_SPIRXDR) begin
				rrdy <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (take) begin
			sb_rdata <= rd_mux; // valid together with the acknowledge.
		end
		if (tx_load) begin
			tx_byte <= sb_req.wdata;
		end
		if (rx_valid) begin
			rx_r <= rx_byte;
		end
	end

endmodule

//--- hdl/spi_bus_pkg.sv
package spi_bus_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// system-bus widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [7:0] sb_addr_t;
	typedef logic [7:0] sb_data_t;

	typedef logic [3:0] spi_phase_t; // one of the 16 SCK edges of a byte.

	// one pending request, held stable for as long as the strobe is up.
	typedef struct packed {
		sb_addr_t addr;
		sb_data_t wdata;
		logic     rw; // 1 means write.
	} sb_req_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// SPI core register map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam sb_addr_t SB_SPICSR  = 8'h00; // bit 0 pulls SSb low.
	localparam sb_addr_t SB_SPIBR   = 8'h01; // SCK half-period is value plus one clocks.
	localparam sb_addr_t SB_SPITXDR = 8'h02; // a write here starts a byte.
	localparam sb_addr_t SB_SPIRXDR = 8'h03;
	localparam sb_addr_t SB_SPISR   = 8'h04;

	// status bits of SB_SPISR.
	localparam int SR_TRDY = 0; // shifter idle.
	localparam int SR_RRDY = 1; // unread byte in SB_SPIRXDR.

endpackage

//--- hdl/spi_flash.sv
module spi_flash #(
	parameter int BITS         = 16,
	parameter int ADDRESS_BITS = 8
) (
	input  logic                    CLK,
	input  logic                    RSTb,
	input  logic [ADDRESS_BITS-1:0] ADDRESS,
	input  logic [BITS-1:0]         DATA_IN,
	output logic [BITS-1:0]         DATA_OUT,
	input  logic                    WR,
	output spi_bus_pkg::sb_req_t    sb_req,
	output logic                    sb_stb,
	input  logic                    sb_ack,
	input  spi_bus_pkg::sb_data_t   sb_rdata
);

	spi_bus_pkg::sb_addr_t addr_r;
	spi_bus_pkg::sb_data_t din_r;
	spi_bus_pkg::sb_data_t dout_r;

	logic wr_addr;
	logic wr_din;
	logic wr_cmd;
	logic go_write;
	logic go_read;
	logic wr_done;
	logic rd_done;

	spi_host_pkg::glue_state_t state;
	spi_host_pkg::glue_state_t state_next;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host window
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign wr_addr = WR && (ADDRESS == ADDRESS_BITS'(spi_host_pkg::HA_ADDR));
	assign wr_din  = WR && (ADDRESS == ADDRESS_BITS'(spi_host_pkg::HA_DIN));
	assign wr_cmd  = WR && (ADDRESS == ADDRESS_BITS'(spi_host_pkg::HA_CMD));

	always_ff @(posedge CLK) begin
		if (wr_addr) begin
			addr_r <= DATA_IN[7:0];
		end
		if (wr_din) begin
			din_r <= DATA_IN[7:0];
		end
	end

	// the command bits only live for one cycle, as go pulses.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			go_write <= 1'b0;
			go_read  <= 1'b0;
		end else begin
			go_write <= wr_cmd && DATA_IN[spi_host_pkg::CMD_GO_WRITE];
			go_read  <= wr_cmd && DATA_IN[spi_host_pkg::CMD_GO_READ];
		end
	end

	always_comb begin
		DATA_OUT = '0; // unreadable addresses return zero.
		if (ADDRESS == ADDRESS_BITS'(spi_host_pkg::HA_DOUT)) begin
			DATA_OUT = BITS'(dout_r);
		end else if (ADDRESS == ADDRESS_BITS'(spi_host_pkg::HA_STAT)) begin
			DATA_OUT[spi_host_pkg::STAT_WR_DONE] = wr_done;
			DATA_OUT[spi_host_pkg::STAT_RD_DONE] = rd_done;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bridge state machine
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		state_next = state;
		case (state)
			spi_host_pkg::ST_IDLE: begin
				if (go_write) begin // write wins when both go bits are set.
					state_next = spi_host_pkg::ST_WRITE;
				end else if (go_read) begin
					state_next = spi_host_pkg::ST_READ;
				end
			end
			spi_host_pkg::ST_READ: begin
				if (sb_ack) begin
					state_next = spi_host_pkg::ST_READ_DONE;
				end
			end
			spi_host_pkg::ST_WRITE: begin
				if (sb_ack) begin
					state_next = spi_host_pkg::ST_WRITE_DONE;
				end
			end
			default: state_next = spi_host_pkg::ST_IDLE; // both done states last one cycle.
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state   <= spi_host_pkg::ST_IDLE;
			wr_done <= 1'b0;
			rd_done <= 1'b0;
			dout_r  <= '0;
		end else begin
			state <= state_next;
			if (state == spi_host_pkg::ST_IDLE && go_write) begin
				wr_done <= 1'b0;
			end else if (state == spi_host_pkg::ST_WRITE_DONE) begin
				wr_done <= 1'b1;
			end
			if (state == spi_host_pkg::ST_IDLE && !go_write && go_read) begin
				rd_done <= 1'b0;
			end else if (state == spi_host_pkg::ST_READ_DONE) begin
				rd_done <= 1'b1;
			end
			if (state == spi_host_pkg::ST_READ && sb_ack) begin
				dout_r <= sb_rdata;
			end
		end
	end

	// the strobe stays up in the request states until the acknowledge.
	assign sb_stb = (state == spi_host_pkg::ST_READ) || (state == spi_host_pkg::ST_WRITE);

	always_comb begin
		sb_req.addr  = addr_r;
		sb_req.wdata = din_r;
		sb_req.rw    = (state == spi_host_pkg::ST_WRITE);
	end

endmodule

//--- hdl/spi_flash_top.sv
module spi_flash_top #(
	parameter int BITS         = 16,
	parameter int ADDRESS_BITS = 8
) (
	input  logic                    CLK,
	input  logic                    RSTb,
	input  logic [ADDRESS_BITS-1:0] ADDRESS,
	input  logic [BITS-1:0]         DATA_IN,
	output logic [BITS-1:0]         DATA_OUT,
	input  logic                    WR,
	output logic                    SCK,
	output logic                    MOSI,
	output logic                    SSb,
	input  logic                    MISO
);

	spi_bus_pkg::sb_req_t  sb_req;
	spi_bus_pkg::sb_data_t sb_rdata;
	spi_bus_pkg::sb_data_t tx_byte;
	spi_bus_pkg::sb_data_t clk_div;
	spi_bus_pkg::sb_data_t rx_byte;

	logic sb_stb;
	logic sb_ack;
	logic tx_start;
	logic cs_active;
	logic busy;
	logic rx_valid;

	spi_flash #(
		.BITS         (BITS),
		.ADDRESS_BITS (ADDRESS_BITS)
	) spi_flash_i (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.ADDRESS  (ADDRESS),
		.DATA_IN  (DATA_IN),
		.DATA_OUT (DATA_OUT),
		.WR       (WR),
		.sb_req   (sb_req),
		.sb_stb   (sb_stb),
		.sb_ack   (sb_ack),
		.sb_rdata (sb_rdata)
	);

	sb_spi_regs sb_spi_regs_i (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.sb_req    (sb_req),
		.sb_stb    (sb_stb),
		.sb_ack    (sb_ack),
		.sb_rdata  (sb_rdata),
		.tx_start  (tx_start),
		.tx_byte   (tx_byte),
		.cs_active (cs_active),
		.clk_div   (clk_div),
		.busy      (busy),
		.rx_valid  (rx_valid),
		.rx_byte   (rx_byte)
	);

	spi_shifter spi_shifter_i (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.tx_start  (tx_start),
		.tx_byte   (tx_byte),
		.cs_active (cs_active),
		.clk_div   (clk_div),
		.busy      (busy),
		.rx_valid  (rx_valid),
		.rx_byte   (rx_byte),
		.SCK       (SCK),
		.MOSI      (MOSI),
		.SSb       (SSb),
		.MISO      (MISO)
	);

endmodule

//--- hdl/spi_host_pkg.sv
package spi_host_pkg;

	typedef logic [7:0]  host_addr_t;
	typedef logic [15:0] host_data_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host register window
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam host_addr_t HA_ADDR = 8'h00; // system-bus address, write only.
	localparam host_addr_t HA_DOUT = 8'h01; // last read result.
	localparam host_addr_t HA_DIN  = 8'h02; // system-bus write data, write only.
	localparam host_addr_t HA_CMD  = 8'h03;
	localparam host_addr_t HA_STAT = 8'h04;

	localparam int CMD_GO_WRITE = 0;
	localparam int CMD_GO_READ  = 1;

	localparam int STAT_WR_DONE = 0;
	localparam int STAT_RD_DONE = 1;

	// states of the bridge that talks to the SPI core.
	typedef enum logic [2:0] {
		ST_IDLE       = 3'd0,
		ST_READ       = 3'd1,
		ST_READ_DONE  = 3'd2,
		ST_WRITE      = 3'd3,
		ST_WRITE_DONE = 3'd4
	} glue_state_t;

endpackage

//--- hdl/spi_shifter.sv
module spi_shifter (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  logic                  tx_start,
	input  spi_bus_pkg::sb_data_t tx_byte,
	input  logic                  cs_active,
	input  spi_bus_pkg::sb_data_t clk_div,
	output logic                  busy,
	output logic                  rx_valid,
	output spi_bus_pkg::sb_data_t rx_byte,
	output logic                  SCK,
	output logic                  MOSI,
	output logic                  SSb,
	input  logic                  MISO
);

	spi_bus_pkg::sb_data_t div_cnt;
	spi_bus_pkg::sb_data_t tx_sr;
	spi_bus_pkg::spi_phase_t phase;

	logic tick;

	// one SCK half-period has elapsed.
	assign tick = busy && (div_cnt == clk_div);
	assign MOSI = tx_sr[7];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// divider and edge counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			busy     <= 1'b0;
			rx_valid <= 1'b0;
			SCK      <= 1'b0;
			SSb      <= 1'b1;
			div_cnt  <= '0;
			phase    <= '0;
		end else begin
			SSb      <= !cs_active;
			rx_valid <= 1'b0;
			if (tx_start && !busy) begin
				busy    <= 1'b1;
				div_cnt <= '0;
				phase   <= '0;
			end else if (tick) begin
				div_cnt <= '0;
				SCK     <= !SCK;
				phase   <= phase + 4'd1;
				if (phase == 4'd15) begin
					// last falling edge, the eighth sample is already in.
					busy     <= 1'b0;
					rx_valid <= 1'b1;
				end
			end else if (busy) begin
				div_cnt <= div_cnt + 8'd1;
			end
		end
	end

	// even phases end in a rising edge, odd phases in a falling one.
	always_ff @(posedge CLK) begin
		if (tx_start && !busy) begin
			tx_sr <= tx_byte; // MSB is on MOSI before the first rising edge.
		end else if (tick && phase[0]) begin
			tx_sr <= {tx_sr[6:0], 1'b0};
		end
		if (tick && !phase[0]) begin
			rx_byte <= {rx_byte[6:0], MISO};
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module spi_flash_tb -Mdir obj_dir -o spi_flash_sim -f sim.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/spi_flash_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "TESTS PASSED"; then
	exit 0
fi
exit 1

//--- sim.f
hdl/spi_bus_pkg.sv
hdl/spi_host_pkg.sv
hdl/spi_flash.sv
hdl/sb_spi_regs.sv
hdl/spi_shifter.sv
hdl/spi_flash_top.sv
sim/flash_model.sv
sim/spi_flash_tb.sv

//--- sim/flash_model.sv
module flash_model (
	input  logic SCK,
	input  logic MOSI,
	input  logic SSb,
	output logic MISO
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0] mem [256];
	logic [7:0] in_sr;
	logic [7:0] out_sr;
	logic [7:0] cmd;
	logic [7:0] addr_ptr;

	int bit_cnt;
	int byte_idx;

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = 8'(i) ^ 8'h5A;
		end
		in_sr    = '0;
		out_sr   = '0;
		cmd      = '0;
		addr_ptr = '0;
		bit_cnt  = 0;
		byte_idx = 0;
		MISO     = 1'b0;
	end

	// mode 0: MOSI is taken on the rising edge, MISO moves on the falling edge.
	always @(posedge SCK or negedge SCK or posedge SSb) begin
		if (SSb) begin
			bit_cnt  = 0; // a new select starts a new command.
			byte_idx = 0;
		end else if (SCK) begin
			in_sr   = {in_sr[6:0], MOSI};
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == 8) begin
				bit_cnt = 0;
				out_sr  = '0;
				if (byte_idx == 0) begin
					cmd = in_sr;
				end else if (byte_idx == 1) begin
					addr_ptr = in_sr;
					out_sr   = mem[addr_ptr];
				end else if (cmd == 8'h02 && byte_idx == 2) begin
					mem[addr_ptr] = in_sr; // program stores a single byte.
				end else if (cmd == 8'h03) begin
					addr_ptr = addr_ptr + 8'd1;
					out_sr   = mem[addr_ptr];
				end
				byte_idx = byte_idx + 1;
			end
		end else begin
			MISO   = out_sr[7];
			out_sr = {out_sr[6:0], 1'b0};
		end
	end

endmodule

//--- sim/spi_flash_tb.sv
module spi_flash_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_CYCLES = 20000;

	logic                     CLK;
	logic                     RSTb;
	logic                     WR;
	spi_host_pkg::host_addr_t ADDRESS;
	spi_host_pkg::host_data_t DATA_IN;
	spi_host_pkg::host_data_t DATA_OUT;
	logic                     SCK;
	logic                     MOSI;
	logic                     SSb;
	logic                     MISO;

	logic [15:0] lfsr_state;
	int          cycle_count = 0;
	int          done_cycles;

	spi_flash_top #(
		.BITS         (16),
		.ADDRESS_BITS (8)
	) spi_flash_top_i (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.ADDRESS  (ADDRESS),
		.DATA_IN  (DATA_IN),
		.DATA_OUT (DATA_OUT),
		.WR       (WR),
		.SCK      (SCK),
		.MOSI     (MOSI),
		.SSb      (SSb),
		.MISO     (MISO)
	);

	flash_model flash_model_i (.SCK(SCK), .MOSI(MOSI), .SSb(SSb), .MISO(MISO));

	initial begin
		CLK = 1'b0;
		forever #2 CLK = !CLK;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reporting and random data
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic abort_run(string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_host(string name, spi_host_pkg::host_data_t exp,
			spi_host_pkg::host_data_t act);
		if (act !== exp) begin
			abort_run($sformatf("CHECK FAILED at %0t ns: %s expected 0x%h, got 0x%h",
				$time, name, exp, act));
		end
	endtask

	task automatic check_sb(string name, spi_bus_pkg::sb_data_t exp, spi_bus_pkg::sb_data_t act);
		if (act !== exp) begin
			abort_run($sformatf("CHECK FAILED at %0t ns: %s expected 0x%h, got 0x%h",
				$time, name, exp, act));
		end
	endtask

	task automatic check_pin(string name, logic exp, logic act);
		if (act !== exp) begin
			abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %b, got %b",
				$time, name, exp, act));
		end
	endtask

	task automatic check_count(string name, int exp, int act);
		if (act != exp) begin
			abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %0d, got %0d",
				$time, name, exp, act));
		end
	endtask

	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hB400;
		end
		return n;
	endfunction

	task automatic random_byte(output spi_bus_pkg::sb_data_t b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit taken.
			b = {b[6:0], lfsr_state[0]};
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host window and system-bus access
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic host_write(spi_host_pkg::host_addr_t a, spi_host_pkg::host_data_t d);
		@(posedge CLK);
		ADDRESS <= a;
		DATA_IN <= d;
		WR      <= 1'b1;
		@(posedge CLK);
		WR <= 1'b0; // the DUT took the write on this edge.
	endtask

	task automatic host_read(spi_host_pkg::host_addr_t a, output spi_host_pkg::host_data_t d);
		@(posedge CLK);
		ADDRESS <= a;
		WR      <= 1'b0;
		@(negedge CLK);
		d = DATA_OUT;
	endtask

	// a flag left over from the last command first drops, then rises again.
	task automatic wait_done(int bitpos);
		int n;
		ADDRESS <= spi_host_pkg::HA_STAT;
		n = 1;
		@(negedge CLK);
		while (DATA_OUT[bitpos]) begin
			@(posedge CLK);
			n++;
			@(negedge CLK);
		end
		while (!DATA_OUT[bitpos]) begin
			@(posedge CLK);
			n++;
			@(negedge CLK);
		end
		done_cycles = n;
	endtask

	task automatic sb_write(spi_bus_pkg::sb_addr_t a, spi_bus_pkg::sb_data_t d);
		host_write(spi_host_pkg::HA_ADDR, spi_host_pkg::host_data_t'(a));
		host_write(spi_host_pkg::HA_DIN, spi_host_pkg::host_data_t'(d));
		host_write(spi_host_pkg::HA_CMD,
			spi_host_pkg::host_data_t'(1 << spi_host_pkg::CMD_GO_WRITE));
		wait_done(spi_host_pkg::STAT_WR_DONE);
	endtask

	task automatic sb_read(spi_bus_pkg::sb_addr_t a, output spi_bus_pkg::sb_data_t d);
		spi_host_pkg::host_data_t hd;
		host_write(spi_host_pkg::HA_ADDR, spi_host_pkg::host_data_t'(a));
		host_write(spi_host_pkg::HA_CMD,
			spi_host_pkg::host_data_t'(1 << spi_host_pkg::CMD_GO_READ));
		wait_done(spi_host_pkg::STAT_RD_DONE);
		host_read(spi_host_pkg::HA_DOUT, hd);
		d = hd[7:0];
	endtask

	task automatic wait_rx(output spi_bus_pkg::sb_data_t d);
		spi_bus_pkg::sb_data_t sr;
		sr = '0;
		while (!sr[spi_bus_pkg::SR_RRDY]) begin
			sb_read(spi_bus_pkg::SB_SPISR, sr);
		end
		sb_read(spi_bus_pkg::SB_SPIRXDR, d);
	endtask

	task automatic spi_xfer(spi_bus_pkg::sb_data_t tx, output spi_bus_pkg::sb_data_t rx);
		sb_write(spi_bus_pkg::SB_SPITXDR, tx);
		wait_rx(rx);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_reset_state();
		spi_host_pkg::host_data_t d;
		host_read(spi_host_pkg::HA_STAT, d);
		check_host("HA_STAT", '0, d);
		host_read(spi_host_pkg::HA_DOUT, d);
		check_host("HA_DOUT", '0, d);
		check_pin("SSb", 1'b1, SSb);
		check_pin("SCK", 1'b0, SCK);
	endtask

	task automatic test_divider_register();
		spi_bus_pkg::sb_data_t v;
		spi_bus_pkg::sb_data_t d;
		random_byte(v);
		sb_write(spi_bus_pkg::SB_SPIBR, v);
		check_count("write-done latency", 5, done_cycles);
		sb_read(spi_bus_pkg::SB_SPIBR, d);
		check_count("read-done latency", 5, done_cycles);
		check_sb("SB_SPIBR", v, d);
		sb_write(spi_bus_pkg::SB_SPIBR, 8'h00); // back to the fastest SCK.
	endtask

	task automatic test_status_idle();
		spi_bus_pkg::sb_data_t sr;
		sb_read(spi_bus_pkg::SB_SPISR, sr);
		check_pin("SR_TRDY", 1'b1, sr[spi_bus_pkg::SR_TRDY]);
		check_pin("SR_RRDY", 1'b0, sr[spi_bus_pkg::SR_RRDY]);
	endtask

	task automatic test_flash_read();
		spi_bus_pkg::sb_data_t a;
		spi_bus_pkg::sb_data_t rx;
		random_byte(a);
		sb_write(spi_bus_pkg::SB_SPICSR, 8'h01);
		spi_xfer(8'h03, rx);
		spi_xfer(a, rx);
		spi_xfer(8'h00, rx);
		sb_write(spi_bus_pkg::SB_SPICSR, 8'h00);
		check_sb("flash read data", a ^ 8'h5A, rx); // the model is preset to address XOR 0x5A.
	endtask

	task automatic test_flash_program();
		spi_bus_pkg::sb_data_t a;
		spi_bus_pkg::sb_data_t v;
		spi_bus_pkg::sb_data_t rx;
		random_byte(a);
		random_byte(v);
		sb_write(spi_bus_pkg::SB_SPICSR, 8'h01);
		spi_xfer(8'h02, rx);
		spi_xfer(a, rx);
		spi_xfer(v, rx);
		sb_write(spi_bus_pkg::SB_SPICSR, 8'h00);
		sb_write(spi_bus_pkg::SB_SPICSR, 8'h01);
		spi_xfer(8'h03, rx);
		spi_xfer(a, rx);
		spi_xfer(8'h00, rx);
		sb_write(spi_bus_pkg::SB_SPICSR, 8'h00);
		check_sb("programmed byte", v, rx);
	endtask

	// SCK is sampled at the falling CLK edge, where it is stable.
	task automatic test_sck_period(spi_bus_pkg::sb_data_t div);
		spi_bus_pkg::sb_data_t rx;
		logic prev;
		int n;
		int last;
		int rises;
		sb_write(spi_bus_pkg::SB_SPIBR, div);
		sb_write(spi_bus_pkg::SB_SPITXDR, 8'hC3);
		prev  = SCK;
		n     = 0;
		last  = 0;
		rises = 0;
		while (rises < 3) begin
			@(negedge CLK);
			n++;
			if (SCK && !prev) begin
				if (rises > 0) begin
					check_count("SCK rising-edge spacing", 2 * (int'(div) + 1), n - last);
				end
				last = n;
				rises++;
			end
			prev = SCK;
		end
		wait_rx(rx);
	endtask

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == MAX_CYCLES) begin
			abort_run("timeout: the tests did not finish within the cycle limit");
		end
	end

	initial begin
		RSTb       = 1'b0;
		WR         = 1'b0;
		ADDRESS    = '0;
		DATA_IN    = '0;
		lfsr_state = 16'd99;
		repeat (3) @(posedge CLK);
		RSTb <= 1'b1;
		test_reset_state();
		test_divider_register();
		test_status_idle();
		test_flash_read();
		test_flash_program();
		test_sck_period(8'd0);
		test_sck_period(8'd3);
		$display("TESTS PASSED");
		$finish;
	end

endmodule
